//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = ts_monitor_tb
FILELIST   = ts_monitor.f
OBJ_DIR    = obj_dir
PASS_TEXT  = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/ctl_pkg.sv
package ctl_pkg;

	typedef enum logic [1:0] {
		CMD_NOP,
		CMD_SET_PID,
		CMD_CAPTURE
	} host_cmd_e;

	// filter entry held by each slot.
	typedef struct packed {
		logic [ts_pkg::PID_W-1:0] pid;
		logic                     enable;
	} pid_entry_t;

	// one word of a captured packet on its way to the host.
	typedef struct packed {
		logic [ts_pkg::WORD_BYTES*8-1:0] data;
		logic [5:0]                      index; // word number, 0 to 46.
		logic                            valid;
	} rd_word_t;

endpackage

//--- logic/host_port.sv
module host_port #(
	parameter  int NUM_SLOTS = 4,
	localparam int SEL_W     = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  ctl_pkg::host_cmd_e         cmd,
	input  logic                       cmd_valid,
	input  logic [SEL_W-1:0]           cmd_slot,
	input  ctl_pkg::pid_entry_t        cmd_entry,
	input  logic [NUM_SLOTS-1:0]       cap_ready,
	input  logic [NUM_SLOTS-1:0][31:0] rd_data,
	output logic [NUM_SLOTS-1:0]       pid_wr,
	output ctl_pkg::pid_entry_t        wr_entry,
	output logic [NUM_SLOTS-1:0]       cap_req,
	output logic [5:0]                 rd_addr,
	output ctl_pkg::rd_word_t          rd_word,
	output logic                       rd_done,
	output logic                       busy
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_WAIT,
		R_READ,
		R_RELEASE
	} rd_state_e;

	rd_state_e        state;
	logic [SEL_W-1:0] rd_slot;
	logic [5:0]       rd_cnt; // word number of the data now on rd_data.
	logic             cap_cmd;

	assign cap_cmd = cmd_valid && (cmd == ctl_pkg::CMD_CAPTURE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pid_wr <= '0;
		end else begin
			pid_wr <= '0;
			if (cmd_valid && (cmd == ctl_pkg::CMD_SET_PID)) begin
				pid_wr[cmd_slot] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			wr_entry <= cmd_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= R_IDLE;
			rd_slot       <= '0;
			rd_cnt        <= '0;
			rd_addr       <= '0;
			cap_req       <= '0;
			busy          <= 1'b0;
			rd_done       <= 1'b0;
			rd_word.valid <= 1'b0;
		end else begin
			cap_req       <= '0;
			rd_done       <= 1'b0;
			rd_word.valid <= 1'b0;
			case (state)
				R_IDLE: begin
					if (cap_cmd) begin
						cap_req[cmd_slot] <= 1'b1; // arms the slot.
						rd_slot           <= cmd_slot;
						busy              <= 1'b1;
						state             <= R_WAIT;
					end
				end
				R_WAIT: begin
					// rd_addr sits at 0 here, so word 0 is already on its way.
					if (cap_ready[rd_slot]) begin
						rd_addr <= 6'd1;
						rd_cnt  <= '0;
						state   <= R_READ;
					end
				end
				R_READ: begin
					rd_word.valid <= 1'b1;
					rd_word.data  <= rd_data[rd_slot];
					rd_word.index <= rd_cnt;
					rd_cnt        <= rd_cnt + 6'd1;
					if (rd_addr != ts_pkg::PACKET_WORDS - 1) begin
						rd_addr <= rd_addr + 6'd1;
					end
					if (rd_cnt == ts_pkg::PACKET_WORDS - 1) begin
						state <= R_RELEASE;
					end
				end
				R_RELEASE: begin
					cap_req[rd_slot] <= 1'b1; // frees the slot for the next capture.
					rd_done          <= 1'b1;
					busy             <= 1'b0;
					rd_addr          <= '0;
					state            <= R_IDLE;
				end
				default: begin
					state <= R_IDLE;
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |-> (cmd_slot < NUM_SLOTS));

endmodule

//--- logic/pid_slot.sv
module pid_slot #(
	parameter int COUNT_W = 32
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                match_enable,
	input  ts_pkg::ts_beat_t    beat,
	input  ts_pkg::ts_hdr_t     hdr,
	input  logic                pid_wr,
	input  ctl_pkg::pid_entry_t wr_entry,
	input  logic                cap_req,
	input  logic [5:0]          rd_addr,
	output ctl_pkg::pid_entry_t entry,
	output logic [COUNT_W-1:0]  count,
	output logic                cap_ready,
	output logic [31:0]         rd_data
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ARMED,
		S_FILL,
		S_HELD
	} slot_state_e;

	slot_state_e state;
	logic        got_start; // byte 0 of the current packet is in the buffer.
	logic        hdr_match;
	logic        buf_wr;
	logic [5:0]  wr_word;
	logic [1:0]  wr_lane;
	logic [31:0] pkt_buf [ts_pkg::PACKET_WORDS];

	assign hdr_match = hdr.valid && entry.enable && match_enable && (hdr.pid == entry.pid);

	// the header bytes are written before the PID is known.
	assign buf_wr  = beat.valid && ((state == S_ARMED) || (state == S_FILL));
	assign wr_word = beat.index[7:2];
	assign wr_lane = beat.index[1:0];

	assign cap_ready = (state == S_HELD);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			entry <= '0;
			count <= '0;
		end else begin
			if (pid_wr) begin
				entry <= wr_entry;
			end
			if (hdr_match) begin
				count <= count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			got_start <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					got_start <= 1'b0;
					if (cap_req) begin
						state <= S_ARMED;
					end
				end
				S_ARMED: begin
					// only a packet seen from its first byte may be kept.
					if (beat.valid && (beat.index == 8'd0)) begin
						got_start <= 1'b1;
					end else if (hdr.valid) begin
						got_start <= 1'b0;
						if (hdr_match && got_start) begin
							state <= S_FILL;
						end
					end
				end
				S_FILL: begin
					if (beat.valid && (beat.index == ts_pkg::PACKET_BYTES - 1)) begin
						state <= S_HELD;
					end
				end
				S_HELD: begin
					if (cap_req) begin
						state <= S_IDLE; // release after readout.
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (buf_wr) begin
			pkt_buf[wr_word][{wr_lane, 3'b000} +: 8] <= beat.data;
		end
		rd_data <= pkt_buf[rd_addr];
	end

	// a held packet stays intact while the host drains it.
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_HELD) |-> !buf_wr);

endmodule

//--- logic/ts_monitor_top.sv
module ts_monitor_top #(
	parameter  int NUM_SLOTS = 4,
	parameter  int COUNT_W   = 32,
	localparam int SEL_W     = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [7:0]                          mpeg_data,
	input  logic                                mpeg_valid,
	input  logic                                mpeg_sync,
	input  ctl_pkg::host_cmd_e                  cmd,
	input  logic                                cmd_valid,
	input  logic [SEL_W-1:0]                    cmd_slot,
	input  ctl_pkg::pid_entry_t                 cmd_entry,
	input  logic                                match_enable,
	output ctl_pkg::rd_word_t                   rd_word,
	output logic                                rd_done,
	output logic                                busy,
	output logic [NUM_SLOTS-1:0][COUNT_W-1:0]   match_count,
	output ctl_pkg::pid_entry_t [NUM_SLOTS-1:0] slot_entry
);

	ts_pkg::ts_beat_t           beat;
	ts_pkg::ts_hdr_t            hdr;
	logic [NUM_SLOTS-1:0]       pid_wr;
	logic [NUM_SLOTS-1:0]       cap_req;
	logic [NUM_SLOTS-1:0]       cap_ready;
	ctl_pkg::pid_entry_t        wr_entry;
	logic [5:0]                 rd_addr;
	logic [NUM_SLOTS-1:0][31:0] rd_data;

	ts_sync_align u_align (
		.clk        (clk),
		.rst_n      (rst_n),
		.mpeg_data  (mpeg_data),
		.mpeg_valid (mpeg_valid),
		.mpeg_sync  (mpeg_sync),
		.beat       (beat),
		.hdr        (hdr)
	);

	// every slot sees the same beats and headers.
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		pid_slot #(
			.COUNT_W (COUNT_W)
		) u_slot (
			.clk          (clk),
			.rst_n        (rst_n),
			.match_enable (match_enable),
			.beat         (beat),
			.hdr          (hdr),
			.pid_wr       (pid_wr[i]),
			.wr_entry     (wr_entry),
			.cap_req      (cap_req[i]),
			.rd_addr      (rd_addr),
			.entry        (slot_entry[i]),
			.count        (match_count[i]),
			.cap_ready    (cap_ready[i]),
			.rd_data      (rd_data[i])
		);
	end

	host_port #(
		.NUM_SLOTS (NUM_SLOTS)
	) u_host (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_slot  (cmd_slot),
		.cmd_entry (cmd_entry),
		.cap_ready (cap_ready),
		.rd_data   (rd_data),
		.pid_wr    (pid_wr),
		.wr_entry  (wr_entry),
		.cap_req   (cap_req),
		.rd_addr   (rd_addr),
		.rd_word   (rd_word),
		.rd_done   (rd_done),
		.busy      (busy)
	);

endmodule

//--- logic/ts_pkg.sv
package ts_pkg;

	// every packet opens with this byte, flagged by mpeg_sync.
	localparam logic [7:0] SYNC_BYTE = 8'h47;

	localparam int PACKET_BYTES = 188;

	// packets are stored four bytes to a word, byte 0 in the low lane.
	localparam int WORD_BYTES   = 4;
	localparam int PACKET_WORDS = PACKET_BYTES / WORD_BYTES;

	localparam int PID_W = 13;

	// one in-lock byte of the stream and its position in the packet.
	typedef struct packed {
		logic [7:0] data;
		logic [7:0] index; // 0 to 187.
		logic       valid;
	} ts_beat_t;

	// strobed with the beat of index 2, once the whole PID is known.
	typedef struct packed {
		logic [PID_W-1:0] pid;
		logic             valid;
	} ts_hdr_t;

endpackage

//--- logic/ts_sync_align.sv
module ts_sync_align (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [7:0]       mpeg_data,
	input  logic             mpeg_valid,
	input  logic             mpeg_sync,
	output ts_pkg::ts_beat_t beat,
	output ts_pkg::ts_hdr_t  hdr
);

	logic       locked;
	logic [7:0] byte_idx; // index the next in-lock byte will take.
	logic [4:0] pid_hi;   // low bits of header byte 1.
	logic       sof;
	logic       take;

	// a flagged byte that is not the sync value does not start a packet.
	assign sof  = mpeg_valid && mpeg_sync && (mpeg_data == ts_pkg::SYNC_BYTE);
	assign take = mpeg_valid && (sof || locked);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			locked     <= 1'b0;
			byte_idx   <= '0;
			beat.valid <= 1'b0;
			hdr.valid  <= 1'b0;
		end else begin
			beat.valid <= take;
			hdr.valid  <= 1'b0;
			if (take) begin
				beat.data <= mpeg_data;
			end
			if (sof) begin
				locked     <= 1'b1;
				byte_idx   <= 8'd1;
				beat.index <= 8'd0;
			end else if (take) begin
				beat.index <= byte_idx;
				byte_idx   <= byte_idx + 8'd1;
				if (byte_idx == 8'd1) begin
					pid_hi <= mpeg_data[4:0];
				end
				if (byte_idx == 8'd2) begin
					hdr.valid <= 1'b1;
					hdr.pid   <= {pid_hi, mpeg_data};
				end
				// the last byte drops lock until the next sync byte.
				if (byte_idx == ts_pkg::PACKET_BYTES - 1) begin
					locked <= 1'b0;
				end
			end
		end
	end

	// a beat index past the packet end would corrupt the slot buffers.
	assert property (@(posedge clk) disable iff (!rst_n)
		beat.valid |-> (beat.index < ts_pkg::PACKET_BYTES));

endmodule

//--- test/ts_monitor_tb.sv
module ts_monitor_tb;

	localparam int NUM_SLOTS       = 4;
	localparam int COUNT_W         = 32;
	localparam int N_PKTS          = 60;
	localparam int WATCHDOG_CYCLES = N_PKTS * 200 + 3000;
	localparam int N_TESTS         = 5;

	logic                                clk;
	logic                                rst_n;
	logic [7:0]                          mpeg_data;
	logic                                mpeg_valid;
	logic                                mpeg_sync;
	ctl_pkg::host_cmd_e                  cmd;
	logic                                cmd_valid;
	logic [1:0]                          cmd_slot;
	ctl_pkg::pid_entry_t                 cmd_entry;
	logic                                match_enable;
	ctl_pkg::rd_word_t                   rd_word;
	logic                                rd_done;
	logic                                busy;
	logic [NUM_SLOTS-1:0][COUNT_W-1:0]   match_count;
	ctl_pkg::pid_entry_t [NUM_SLOTS-1:0] slot_entry;

	// reference model of the slots and of the host readout.
	ctl_pkg::pid_entry_t     model_entry [NUM_SLOTS];
	int unsigned             model_count [NUM_SLOTS];
	logic [31:0]             exp_words [ts_pkg::PACKET_WORDS];
	logic [7:0]              pkt [ts_pkg::PACKET_BYTES];
	logic [ts_pkg::PID_W-1:0] pid_pool [4] = '{13'h0100, 13'h0011, 13'h1abc, 13'h0f35};
	int                      cap_state; // 0 idle, 1 armed, 2 draining.
	int                      cap_slot;
	int                      cap_next;
	bit                      exp_active;
	int                      rd_idx;
	int                      caps_expected;
	int                      caps_done;
	int                      caps_ignored;
	int                      checks;
	int                      errors;
	int                      test_err [N_TESTS];
	logic [31:0]             rng_state = 32'd88;

	ts_monitor_top #(
		.NUM_SLOTS (NUM_SLOTS),
		.COUNT_W   (COUNT_W)
	) dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.mpeg_data    (mpeg_data),
		.mpeg_valid   (mpeg_valid),
		.mpeg_sync    (mpeg_sync),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.cmd_slot     (cmd_slot),
		.cmd_entry    (cmd_entry),
		.match_enable (match_enable),
		.rd_word      (rd_word),
		.rd_done      (rd_done),
		.busy         (busy),
		.match_count  (match_count),
		.slot_entry   (slot_entry)
	);

	function automatic logic [31:0] rand_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_below(int n);
		return int'(rand_next() >> 8) % n;
	endfunction

	task automatic check_value(int t, string name, logic [63:0] got, logic [63:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("[FAIL] t=%0t %s: got %0h expected %0h", $time, name, got, exp);
			errors++;
			test_err[t]++;
		end
	endtask

	task automatic check_true(int t, bit cond, string what);
		checks++;
		assert (cond) else begin
			$display("error at t=%0t: %s", $time, what);
			errors++;
			test_err[t]++;
		end
	endtask

	task automatic finish_test(int t, string name);
		if (test_err[t] == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_err[t]);
		end
	endtask

	task automatic issue_cmd(ctl_pkg::host_cmd_e op, int slot, ctl_pkg::pid_entry_t e);
		@(posedge clk);
		cmd       <= op;
		cmd_slot  <= 2'(slot);
		cmd_entry <= e;
		cmd_valid <= 1'b1;
		@(posedge clk);
		cmd       <= ctl_pkg::CMD_NOP;
		cmd_valid <= 1'b0;
	endtask

	// a request made while the host port is busy must not arm anything.
	task automatic try_capture();
		int s;
		s = cap_next;
		issue_cmd(ctl_pkg::CMD_CAPTURE, s, '0);
		@(negedge clk);
		check_value(4, "busy after capture command", 64'(busy), 64'd1);
		if (cap_state == 0) begin
			cap_state = 1;
			cap_slot  = s;
			cap_next  = (cap_next + 1) % 3;
			caps_expected++;
		end else begin
			caps_ignored++;
		end
	endtask

	task automatic send_packet(logic [ts_pkg::PID_W-1:0] pid, bit good, bit me);
		bit draining;
		draining = (cap_state == 2);
		pkt[0] = good ? ts_pkg::SYNC_BYTE : (ts_pkg::SYNC_BYTE ^ 8'(1 + rand_below(255)));
		pkt[1] = {3'(rand_below(8)), pid[12:8]}; // flag bits are random.
		pkt[2] = pid[7:0];
		for (int i = 3; i < ts_pkg::PACKET_BYTES; i++) begin
			pkt[i] = 8'(rand_below(256));
		end
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (good && me && model_entry[s].enable && (model_entry[s].pid == pid)) begin
				model_count[s]++;
				if ((cap_state == 1) && (cap_slot == s)) begin
					for (int w = 0; w < ts_pkg::PACKET_WORDS; w++) begin
						exp_words[w] = {pkt[4*w+3], pkt[4*w+2], pkt[4*w+1], pkt[4*w]};
					end
					rd_idx     = 0;
					exp_active = 1'b1;
					cap_state  = 2;
				end
			end
		end
		@(posedge clk);
		match_enable <= me;
		for (int i = 0; i < ts_pkg::PACKET_BYTES; i++) begin
			@(posedge clk);
			mpeg_valid <= 1'b1;
			mpeg_sync  <= (i == 0);
			mpeg_data  <= pkt[i];
		end
		@(posedge clk);
		mpeg_valid <= 1'b0;
		mpeg_sync  <= 1'b0;
		repeat (1 + rand_below(6)) @(posedge clk);
		// a readout lasts about 52 cycles, far less than one packet.
		if (draining) begin
			cap_state = 0;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && rd_word.valid) begin
			if (!exp_active || (rd_idx >= ts_pkg::PACKET_WORDS)) begin
				check_true(3, 1'b0, "readout word arrived with no capture pending");
			end else begin
				check_value(3, $sformatf("rd_word.index (word %0d)", rd_idx),
					64'(rd_word.index), 64'(rd_idx));
				check_value(3, $sformatf("rd_word.data (word %0d)", rd_idx),
					64'(rd_word.data), 64'(exp_words[rd_idx]));
				rd_idx++;
			end
		end
		if (rst_n && rd_done) begin
			check_true(3, exp_active, "rd_done pulsed with no capture in progress");
			check_value(3, "words before rd_done", 64'(rd_idx), 64'(ts_pkg::PACKET_WORDS));
			check_value(4, "busy at rd_done", 64'(busy), 64'd0);
			exp_active = 1'b0;
			caps_done++;
		end
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		ctl_pkg::pid_entry_t e;
		rst_n        = 1'b0;
		mpeg_data    = '0;
		mpeg_valid   = 1'b0;
		mpeg_sync    = 1'b0;
		cmd          = ctl_pkg::CMD_NOP;
		cmd_valid    = 1'b0;
		cmd_slot     = '0;
		cmd_entry    = '0;
		match_enable = 1'b0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			model_entry[s] = '0;
			model_count[s] = 0;
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		check_value(0, "busy", 64'(busy), 64'd0);
		check_value(0, "rd_done", 64'(rd_done), 64'd0);
		check_value(0, "rd_word.valid", 64'(rd_word.valid), 64'd0);
		for (int s = 0; s < NUM_SLOTS; s++) begin
			check_value(0, $sformatf("match_count[%0d]", s), 64'(match_count[s]), 64'd0);
			check_value(0, $sformatf("slot_entry[%0d]", s), 64'(slot_entry[s]), 64'd0);
		end
		finish_test(0, "reset_values");

		// slots 0 and 2 share a PID, slot 3 stays disabled.
		for (int s = 0; s < NUM_SLOTS; s++) begin
			e.pid    = pid_pool[(s == 1) ? 1 : ((s == 3) ? 2 : 0)];
			e.enable = (s != 3);
			issue_cmd(ctl_pkg::CMD_SET_PID, s, e);
			model_entry[s] = e;
			@(posedge clk);
			@(negedge clk);
			for (int k = 0; k < NUM_SLOTS; k++) begin
				check_value(1, $sformatf("slot_entry[%0d]", k),
					64'(slot_entry[k]), 64'(model_entry[k]));
			end
		end
		finish_test(1, "set_pid");

		for (int n = 0; n < N_PKTS; n++) begin
			send_packet(pid_pool[rand_below(4)], rand_below(8) != 0, rand_below(5) != 0);
			if ((cap_state == 2) || (rand_below(3) == 0)) begin
				try_capture();
			end
		end
		while (cap_state != 0) begin
			send_packet(model_entry[cap_slot].pid, 1'b1, 1'b1);
		end
		for (int i = 0; (i < 200) && busy; i++) begin
			@(negedge clk);
		end
		check_true(4, !busy, "busy still high after the stream ended");

		for (int s = 0; s < NUM_SLOTS; s++) begin
			check_value(2, $sformatf("match_count[%0d]", s),
				64'(match_count[s]), 64'(model_count[s]));
		end
		finish_test(2, "stream_counts");
		check_value(3, "captures completed", 64'(caps_done), 64'(caps_expected));
		finish_test(3, "capture_readout");
		check_true(4, caps_ignored > 0, "no capture request was made while busy");
		finish_test(4, "busy_ignore");

		$display("checks: %0d, errors: %0d, captures: %0d, ignored requests: %0d",
			checks, errors, caps_done, caps_ignored);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- ts_monitor.f
logic/ts_pkg.sv
logic/ctl_pkg.sv
logic/ts_sync_align.sv
logic/pid_slot.sv
logic/host_port.sv
logic/ts_monitor_top.sv
test/ts_monitor_tb.sv
